// ==== design/rvv_isa_pkg.sv ====
`default_nettype none

package rvv_isa_pkg;

  // Major opcodes seen on the accelerator port
  typedef enum logic [6:0] {
    OP_LOAD_FP  = 7'b0000111,
    OP_STORE_FP = 7'b0100111,
    OP_VEC      = 7'b1010111,
    OP_SYSTEM   = 7'b1110011
  } opcode_e;

  // funct3 of OP-V selects the operand class
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPCFG = 3'b111
  } vfunct3_e;

  typedef enum logic [11:0] {
    CSR_VSTART = 12'h008,
    CSR_VL     = 12'hC20,
    CSR_VTYPE  = 12'hC21,
    CSR_VLENB  = 12'hC22
  } csr_addr_e;

  localparam logic [2:0] CSR_FUNCT3_CSRRW  = 3'b001;
  localparam logic [2:0] CSR_FUNCT3_CSRRS  = 3'b010;
  localparam logic [2:0] CSR_FUNCT3_CSRRC  = 3'b011;
  localparam logic [2:0] CSR_FUNCT3_CSRRWI = 3'b101;
  localparam logic [2:0] CSR_FUNCT3_CSRRSI = 3'b110;
  localparam logic [2:0] CSR_FUNCT3_CSRRCI = 3'b111;

  // Top seven bits of vsetvl
  localparam logic [6:0] VSETVL_FUNC7 = 7'b1000000;

  typedef struct packed {
    logic [5:0] funct6;
    logic       vm;
    logic [4:0] rs2;
    logic [4:0] rs1;
    vfunct3_e   funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } varith_fmt_t;

  // vsetvli has bit 31 clear, vsetvl carries func7 in bits 31:25
  typedef struct packed {
    logic       func1;
    logic       zimm_b10;
    logic [9:0] zimm10;
    logic [4:0] rs1;
    vfunct3_e   funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } vsetvl_fmt_t;

  typedef union packed {
    varith_fmt_t varith;
    vsetvl_fmt_t vsetvl;
  } rvv_insn_u;

endpackage

`default_nettype wire

// ==== design/vdisp_pkg.sv ====
`default_nettype none

package vdisp_pkg;

  localparam int unsigned XLEN = 64;

  // Vector length or element index
  typedef logic [15:0] vlen_t;

  typedef enum logic [2:0] {
    EW8    = 3'b000,
    EW16   = 3'b001,
    EW32   = 3'b010,
    EW64   = 3'b011,
    EW128  = 3'b100,
    EW256  = 3'b101,
    EW512  = 3'b110,
    EW1024 = 3'b111
  } vew_e;

  // Fractional values are the negative two's complement codes
  typedef enum logic [2:0] {
    LMUL_1    = 3'b000,
    LMUL_2    = 3'b001,
    LMUL_4    = 3'b010,
    LMUL_8    = 3'b011,
    LMUL_RSVD = 3'b100,
    LMUL_1_8  = 3'b101,
    LMUL_1_4  = 3'b110,
    LMUL_1_2  = 3'b111
  } vlmul_e;

  typedef struct packed {
    logic   vill;
    logic   vma;
    logic   vta;
    vew_e   vsew;
    vlmul_e vlmul;
  } vtype_t;

  localparam vtype_t VTYPE_ILLEGAL = '{vill: 1'b1, vma: 1'b0, vta: 1'b0,
                                       vsew: EW8, vlmul: LMUL_1};

  typedef enum logic [4:0] {
    VADD, VSUB, VRSUB, VMINU, VMIN, VMAXU, VMAX,
    VAND, VOR, VXOR, VMERGE, VSLL, VSRL, VSRA
  } vop_e;

  typedef struct packed {
    logic [2:0]      trans_id;
    logic [31:0]     insn;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
  } acc_req_t;

  typedef struct packed {
    logic [2:0]      trans_id;
    logic [XLEN-1:0] result;
    logic            error;
  } acc_resp_t;

  typedef struct packed {
    vop_e            op;
    logic [4:0]      vs1;
    logic            use_vs1;
    logic [4:0]      vs2;
    logic            use_vs2;
    logic [4:0]      vd;
    logic            vm;
    logic [XLEN-1:0] scalar_op;
    logic            use_scalar_op;
    vlen_t           vl;
    vlen_t           vstart;
    vtype_t          vtype;
  } ara_req_t;

  typedef struct packed {
    vlen_t  vl;
    vlen_t  vstart;
    vtype_t vtype;
  } vcfg_t;

endpackage

`default_nettype wire

// ==== design/vcfg_csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module vcfg_csr_unit #(
  parameter int unsigned VLEN = 512,
  parameter int unsigned ELEN = 64
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  vdisp_pkg::acc_req_t        acc_req_i,
  input  logic                       cfg_sel_i,
  input  logic                       csr_sel_i,
  input  logic                       accept_i,
  input  logic                       ara_idle_i,
  output vdisp_pkg::vcfg_t           vcfg_o,
  output logic                       waiting_o,
  output logic [vdisp_pkg::XLEN-1:0] csr_result_o,
  output logic                       csr_err_o
);

  import vdisp_pkg::*;
  import rvv_isa_pkg::*;

  localparam int unsigned VLENB = VLEN / 8;
  // Widest legal element on the vsew scale
  localparam logic signed [4:0] ELEN_SEW = 5'($clog2(ELEN / 8));

  vtype_t            vtype_q, vtype_d, vtype_req, vtype_set;
  vlen_t             vl_q, vl_d, vl_set, vlmax;
  vlen_t             vstart_q, vstart_d, vstart_set;
  logic              wait_q, wait_d;
  rvv_insn_u         insn;
  logic              is_vsetvl;
  logic              cfg_bad;
  logic              vtype_bad;
  logic [7:0]        vtype_byte;
  logic signed [4:0] sew_log;
  logic signed [4:0] lmul_log;
  csr_addr_e         csr_addr;
  logic [2:0]        csr_funct3;
  logic [XLEN-1:0]   csr_operand;
  logic [XLEN-1:0]   csr_rdata;
  logic              csr_bad;

  function automatic vtype_t vtype_from_byte(logic [7:0] b);
    vtype_t vt;
    vt.vill  = 1'b0;
    vt.vma   = b[7];
    vt.vta   = b[6];
    vt.vsew  = vew_e'(b[4:2]);
    vt.vlmul = vlmul_e'({b[5], b[1:0]});
    return vt;
  endfunction

  // CSR view of vtype, vill sits in the top bit
  function automatic logic [XLEN-1:0] vtype_to_xlen(vtype_t vt);
    return {vt.vill, {(XLEN-9){1'b0}}, vt.vma, vt.vta, vt.vlmul[2], vt.vsew, vt.vlmul[1:0]};
  endfunction

  assign insn = acc_req_i.insn;

  assign is_vsetvl  = {insn.vsetvl.func1, insn.vsetvl.zimm_b10, insn.vsetvl.zimm10[9:5]}
                      == VSETVL_FUNC7;
  assign cfg_bad    = insn.vsetvl.func1 && !is_vsetvl;
  assign vtype_byte = is_vsetvl ? acc_req_i.rs2[7:0] : insn.vsetvl.zimm10[7:0];
  assign vtype_req  = vtype_from_byte(vtype_byte);

  // Legality in log2 terms: SEW <= ELEN and LMUL >= SEW/ELEN
  assign sew_log   = signed'({2'b00, 3'(vtype_req.vsew)});
  assign lmul_log  = 5'(signed'(3'(vtype_req.vlmul)));
  assign vtype_bad = (sew_log > ELEN_SEW) || (vtype_req.vlmul == LMUL_RSVD) ||
                     (ELEN_SEW + lmul_log < sew_log);

  always_comb begin
    vlmax = vlen_t'(VLENB >> vtype_req.vsew);
    case (vtype_req.vlmul)
      LMUL_2:   vlmax = vlmax << 1;
      LMUL_4:   vlmax = vlmax << 2;
      LMUL_8:   vlmax = vlmax << 3;
      LMUL_1_2: vlmax = vlmax >> 1;
      LMUL_1_4: vlmax = vlmax >> 2;
      LMUL_1_8: vlmax = vlmax >> 3;
      default:  vlmax = vlmax;
    endcase
  end

  always_comb begin
    vtype_set = vtype_req;
    if (vtype_bad) begin
      vtype_set = VTYPE_ILLEGAL;
      vl_set    = '0;
    end else if (insn.vsetvl.rs1 == '0 && insn.vsetvl.rd == '0) begin
      vl_set = vl_q;
    end else if (insn.vsetvl.rs1 == '0) begin
      vl_set = vlmax;
    end else if (acc_req_i.rs1 > XLEN'(vlmax)) begin
      vl_set = vlmax;
    end else begin
      vl_set = vlen_t'(acc_req_i.rs1);
    end
  end

  assign csr_addr    = csr_addr_e'(acc_req_i.insn[31:20]);
  assign csr_funct3  = acc_req_i.insn[14:12];
  // Immediate forms use the zero-extended rs1 field
  assign csr_operand = csr_funct3[2] ? XLEN'(insn.varith.rs1) : acc_req_i.rs1;

  always_comb begin
    csr_rdata  = '0;
    csr_bad    = 1'b0;
    vstart_set = vstart_q;
    case (csr_addr)
      CSR_VSTART: begin
        csr_rdata = XLEN'(vstart_q);
        case (csr_funct3[1:0])
          2'b01:   vstart_set = vlen_t'(csr_operand);
          2'b10:   vstart_set = vstart_q | vlen_t'(csr_operand);
          2'b11:   vstart_set = vstart_q & ~vlen_t'(csr_operand);
          default: csr_bad = 1'b1;
        endcase
      end
      CSR_VL:    csr_rdata = XLEN'(vl_q);
      CSR_VTYPE: csr_rdata = vtype_to_xlen(vtype_q);
      CSR_VLENB: csr_rdata = XLEN'(VLENB);
      default:   csr_bad = 1'b1;
    endcase
    // Read-only CSRs take set or clear with a zero source only
    if (csr_addr != CSR_VSTART && (insn.varith.rs1 != '0 || csr_funct3[1:0] == 2'b01)) begin
      csr_bad = 1'b1;
    end
  end

  // A config instruction returns its new vl
  assign csr_result_o = cfg_sel_i ? XLEN'(vl_set) : csr_rdata;
  assign csr_err_o    = cfg_sel_i ? cfg_bad : csr_bad;

  assign waiting_o = wait_q && !ara_idle_i;
  assign vcfg_o    = '{vl: vl_q, vstart: vstart_q, vtype: vtype_q};

  always_comb begin
    vtype_d  = vtype_q;
    vl_d     = vl_q;
    vstart_d = vstart_q;
    wait_d   = waiting_o;
    if (accept_i && cfg_sel_i && !cfg_bad) begin
      vtype_d = vtype_set;
      vl_d    = vl_set;
      // Backend drains before it sees a new vtype
      if (vtype_set != vtype_q) begin
        wait_d = 1'b1;
      end
    end
    if (accept_i && csr_sel_i && !csr_bad) begin
      vstart_d = vstart_set;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vtype_q  <= VTYPE_ILLEGAL;
      vl_q     <= '0;
      vstart_q <= '0;
      wait_q   <= 1'b0;
    end else begin
      vtype_q  <= vtype_d;
      vl_q     <= vl_d;
      vstart_q <= vstart_d;
      wait_q   <= wait_d;
    end
  end

endmodule

`default_nettype wire

// ==== design/varith_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module varith_decoder (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  vdisp_pkg::acc_req_t acc_req_i,
  input  logic                arith_sel_i,
  input  logic                accept_i,
  input  logic                ara_req_ready_i,
  input  vdisp_pkg::vcfg_t    vcfg_i,
  output vdisp_pkg::ara_req_t ara_req_o,
  output logic                ara_req_valid_o,
  output logic                arith_err_o
);

  import vdisp_pkg::*;
  import rvv_isa_pkg::*;

  rvv_insn_u  insn;
  ara_req_t   req_d;
  logic       is_vv;
  logic       is_vx;
  logic       is_vi;
  logic       f6_bad;
  logic       misaligned;
  logic [4:0] lmul_mask;

  assign insn  = acc_req_i.insn;
  assign is_vv = insn.varith.funct3 == OPIVV;
  assign is_vx = insn.varith.funct3 == OPIVX;
  assign is_vi = insn.varith.funct3 == OPIVI;

  always_comb begin
    req_d         = '0;
    f6_bad        = 1'b0;
    req_d.vs2     = insn.varith.rs2;
    req_d.use_vs2 = 1'b1;
    req_d.vd      = insn.varith.rd;
    req_d.vm      = insn.varith.vm;
    req_d.vl      = vcfg_i.vl;
    req_d.vstart  = vcfg_i.vstart;
    req_d.vtype   = vcfg_i.vtype;

    // Second operand source by class
    if (is_vv) begin
      req_d.vs1     = insn.varith.rs1;
      req_d.use_vs1 = 1'b1;
    end else if (is_vx) begin
      req_d.scalar_op     = acc_req_i.rs1;
      req_d.use_scalar_op = 1'b1;
    end else if (is_vi) begin
      req_d.scalar_op     = {{(XLEN-5){insn.varith.rs1[4]}}, insn.varith.rs1};
      req_d.use_scalar_op = 1'b1;
    end

    case (insn.varith.funct6)
      6'b000000: req_d.op = VADD;
      6'b000010: req_d.op = VSUB;
      6'b000011: req_d.op = VRSUB;
      6'b000100: req_d.op = VMINU;
      6'b000101: req_d.op = VMIN;
      6'b000110: req_d.op = VMAXU;
      6'b000111: req_d.op = VMAX;
      6'b001001: req_d.op = VAND;
      6'b001010: req_d.op = VOR;
      6'b001011: req_d.op = VXOR;
      6'b010111: req_d.op = VMERGE;
      6'b100101: req_d.op = VSLL;
      6'b101000: req_d.op = VSRL;
      6'b101001: req_d.op = VSRA;
      default:   f6_bad = 1'b1;
    endcase

    // Gaps in the per-class tables
    if ((req_d.op == VSUB && is_vi) || (req_d.op == VRSUB && is_vv)) begin
      f6_bad = 1'b1;
    end
    if (req_d.op inside {VMINU, VMIN, VMAXU, VMAX} && is_vi) begin
      f6_bad = 1'b1;
    end
  end

  // Register groups under integer LMUL start on a multiple of LMUL
  always_comb begin
    case (vcfg_i.vtype.vlmul)
      LMUL_2:  lmul_mask = 5'b00001;
      LMUL_4:  lmul_mask = 5'b00011;
      LMUL_8:  lmul_mask = 5'b00111;
      default: lmul_mask = 5'b00000;
    endcase
  end

  assign misaligned = (|(insn.varith.rd & lmul_mask)) ||
                      (|(insn.varith.rs2 & lmul_mask)) ||
                      (is_vv && (|(insn.varith.rs1 & lmul_mask)));

  assign arith_err_o = f6_bad || misaligned || vcfg_i.vtype.vill;

  // Request register loads only while the backend is ready
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ara_req_valid_o <= 1'b0;
    end else if (ara_req_ready_i) begin
      ara_req_valid_o <= accept_i && arith_sel_i && !arith_err_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ara_req_ready_i) begin
      ara_req_o <= req_d;
    end
  end

endmodule

`default_nettype wire

// ==== design/dispatch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatch_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  vdisp_pkg::acc_req_t        acc_req_i,
  input  logic                       acc_req_valid_i,
  input  logic                       acc_resp_ready_i,
  input  logic                       ara_req_ready_i,
  input  logic                       waiting_i,
  input  logic [vdisp_pkg::XLEN-1:0] csr_result_i,
  input  logic                       csr_err_i,
  input  logic                       arith_err_i,
  output logic                       acc_req_ready_o,
  output vdisp_pkg::acc_resp_t       acc_resp_o,
  output logic                       acc_resp_valid_o,
  output logic                       cfg_sel_o,
  output logic                       csr_sel_o,
  output logic                       arith_sel_o,
  output logic                       accept_o
);

  import vdisp_pkg::*;
  import rvv_isa_pkg::*;

  rvv_insn_u insn;
  logic      illegal;
  logic      active_q;
  logic      candidate;

  assign insn = acc_req_i.insn;

  always_comb begin
    cfg_sel_o   = 1'b0;
    csr_sel_o   = 1'b0;
    arith_sel_o = 1'b0;
    illegal     = 1'b0;
    case (insn.varith.opcode)
      OP_VEC: begin
        case (insn.varith.funct3)
          OPCFG:               cfg_sel_o   = 1'b1;
          OPIVV, OPIVX, OPIVI: arith_sel_o = 1'b1;
          // OPMVV and the float classes land here
          default:             illegal     = 1'b1;
        endcase
      end
      OP_SYSTEM: begin
        case (3'(insn.varith.funct3))
          CSR_FUNCT3_CSRRW, CSR_FUNCT3_CSRRS, CSR_FUNCT3_CSRRC,
          CSR_FUNCT3_CSRRWI, CSR_FUNCT3_CSRRSI, CSR_FUNCT3_CSRRCI: csr_sel_o = 1'b1;
          default: illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase
  end

  // No acceptance until the first edge after reset release
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
    end else begin
      active_q <= 1'b1;
    end
  end

  assign candidate = active_q && acc_req_valid_i && acc_resp_ready_i && !waiting_i;
  // Arithmetic also needs room in the request register
  assign accept_o  = candidate && (!arith_sel_o || ara_req_ready_i);

  assign acc_req_ready_o  = accept_o;
  assign acc_resp_valid_o = accept_o;

  always_comb begin
    acc_resp_o          = '0;
    acc_resp_o.trans_id = acc_req_i.trans_id;
    if (cfg_sel_o || csr_sel_o) begin
      acc_resp_o.result = csr_result_i;
      acc_resp_o.error  = csr_err_i;
    end else if (arith_sel_o) begin
      acc_resp_o.error = arith_err_i;
    end else begin
      acc_resp_o.error = illegal;
    end
  end

endmodule

`default_nettype wire

// ==== design/vector_dispatcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_dispatcher #(
  parameter int unsigned VLEN = 512,
  parameter int unsigned ELEN = 64
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  vdisp_pkg::acc_req_t  acc_req_i,
  input  logic                 acc_req_valid_i,
  output logic                 acc_req_ready_o,
  output vdisp_pkg::acc_resp_t acc_resp_o,
  output logic                 acc_resp_valid_o,
  input  logic                 acc_resp_ready_i,
  output vdisp_pkg::ara_req_t  ara_req_o,
  output logic                 ara_req_valid_o,
  input  logic                 ara_req_ready_i,
  input  logic                 ara_idle_i
);

  import vdisp_pkg::*;

  vcfg_t           vcfg;
  logic            waiting;
  logic [XLEN-1:0] csr_result;
  logic            csr_err;
  logic            arith_err;
  logic            cfg_sel;
  logic            csr_sel;
  logic            arith_sel;
  logic            accept;

  dispatch_ctrl u_dispatch_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .acc_req_i        (acc_req_i),
    .acc_req_valid_i  (acc_req_valid_i),
    .acc_resp_ready_i (acc_resp_ready_i),
    .ara_req_ready_i  (ara_req_ready_i),
    .waiting_i        (waiting),
    .csr_result_i     (csr_result),
    .csr_err_i        (csr_err),
    .arith_err_i      (arith_err),
    .acc_req_ready_o  (acc_req_ready_o),
    .acc_resp_o       (acc_resp_o),
    .acc_resp_valid_o (acc_resp_valid_o),
    .cfg_sel_o        (cfg_sel),
    .csr_sel_o        (csr_sel),
    .arith_sel_o      (arith_sel),
    .accept_o         (accept)
  );

  vcfg_csr_unit #(
    .VLEN (VLEN),
    .ELEN (ELEN)
  ) u_vcfg_csr_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .acc_req_i    (acc_req_i),
    .cfg_sel_i    (cfg_sel),
    .csr_sel_i    (csr_sel),
    .accept_i     (accept),
    .ara_idle_i   (ara_idle_i),
    .vcfg_o       (vcfg),
    .waiting_o    (waiting),
    .csr_result_o (csr_result),
    .csr_err_o    (csr_err)
  );

  varith_decoder u_varith_decoder (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .acc_req_i       (acc_req_i),
    .arith_sel_i     (arith_sel),
    .accept_i        (accept),
    .ara_req_ready_i (ara_req_ready_i),
    .vcfg_i          (vcfg),
    .ara_req_o       (ara_req_o),
    .ara_req_valid_o (ara_req_valid_o),
    .arith_err_o     (arith_err)
  );

endmodule

`default_nettype wire

// ==== sim/vector_dispatcher_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_dispatcher_properties (
  input wire logic                clk_i,
  input wire logic                rst_ni,
  input wire vdisp_pkg::ara_req_t ara_req_o,
  input wire logic                ara_req_valid_o,
  input wire logic                ara_req_ready_i,
  input wire logic                acc_req_valid_i,
  input wire logic                acc_req_ready_o,
  input wire logic                acc_resp_valid_o,
  input wire logic                acc_resp_ready_i
);

  // Assertion failures that the testbench adds to its count
  int unsigned assert_fails = 0;

  reset_clears_valid: assert property (@(posedge clk_i) !rst_ni |-> !ara_req_valid_o)
    else begin
      $error("ara_req_valid_o high during reset");
      assert_fails++;
    end

  // Backend request holds under back-pressure
  req_held_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ara_req_valid_o && !ara_req_ready_i |=> ara_req_valid_o && $stable(ara_req_o))
    else begin
      $error("ara_req_o changed while stalled");
      assert_fails++;
    end

  // A response goes out only for an offered request that the core can take back
  resp_needs_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    acc_resp_valid_o |-> acc_req_ready_o && acc_req_valid_i && acc_resp_ready_i)
    else begin
      $error("response given without acceptance");
      assert_fails++;
    end

endmodule

bind vector_dispatcher vector_dispatcher_properties u_props (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .ara_req_o        (ara_req_o),
  .ara_req_valid_o  (ara_req_valid_o),
  .ara_req_ready_i  (ara_req_ready_i),
  .acc_req_valid_i  (acc_req_valid_i),
  .acc_req_ready_o  (acc_req_ready_o),
  .acc_resp_valid_o (acc_resp_valid_o),
  .acc_resp_ready_i (acc_resp_ready_i)
);

`default_nettype wire

// ==== sim/vector_dispatcher_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_dispatcher_tb;

  import vdisp_pkg::*;
  import rvv_isa_pkg::*;

  localparam int unsigned VLEN = 512;
  localparam int unsigned ELEN = 64;
  localparam int CLK_PERIOD = 8;

  typedef struct {
    string       name;
    logic [31:0] insn;
    logic [63:0] rs1;
    logic [63:0] rs2;
    bit          idle_low;
  } entry_t;

  logic      clk_i;
  logic      rst_ni;
  acc_req_t  acc_req_i;
  logic      acc_req_valid_i;
  logic      acc_req_ready_o;
  acc_resp_t acc_resp_o;
  logic      acc_resp_valid_o;
  logic      acc_resp_ready_i;
  ara_req_t  ara_req_o;
  logic      ara_req_valid_o;
  logic      ara_req_ready_i;
  logic      ara_idle_i;

  entry_t      tbl[$];
  bit          table_built = 1'b0;
  int unsigned resp_errs = 0;
  int unsigned req_errs = 0;
  int unsigned bit_errs = 0;

  // Reference configuration state
  vtype_t      m_vtype;
  int unsigned m_vl;
  int unsigned m_vstart;
  bit          m_wait;

  vector_dispatcher #(.VLEN(VLEN), .ELEN(ELEN)) u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] enc_cfgi(logic [4:0] rd, logic [4:0] rs1, logic [7:0] zimm);
    return {4'b0000, zimm, rs1, 3'b111, rd, 7'b1010111};
  endfunction

  function automatic logic [31:0] enc_cfg(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return {7'b1000000, rs2, rs1, 3'b111, rd, 7'b1010111};
  endfunction

  function automatic logic [31:0] enc_op(logic [5:0] f6, logic vm, logic [4:0] vs2,
                                         logic [4:0] rs1, logic [2:0] f3, logic [4:0] vd);
    return {f6, vm, vs2, rs1, f3, vd, 7'b1010111};
  endfunction

  function automatic logic [31:0] enc_csr(logic [11:0] addr, logic [4:0] rs1, logic [2:0] f3);
    return {addr, rs1, f3, 5'd6, 7'b1110011};
  endfunction

  task automatic add(string name, logic [31:0] insn, logic [63:0] rs1 = 0,
                     logic [63:0] rs2 = 0, bit idle_low = 0);
    entry_t e;
    e.name = name;
    e.insn = insn;
    e.rs1 = rs1;
    e.rs2 = rs2;
    e.idle_low = idle_low;
    tbl.push_back(e);
  endtask

  function automatic int unsigned sew_bits(vtype_t vt);
    return 8 << vt.vsew;
  endfunction

  // LMUL >= SEW/ELEN, SEW <= ELEN, no reserved LMUL
  function automatic bit vtype_legal(vtype_t vt);
    case (vt.vlmul)
      LMUL_RSVD: return 0;
      LMUL_1_2:  return sew_bits(vt) * 2 <= ELEN;
      LMUL_1_4:  return sew_bits(vt) * 4 <= ELEN;
      LMUL_1_8:  return sew_bits(vt) * 8 <= ELEN;
      default:   return sew_bits(vt) <= ELEN;
    endcase
  endfunction

  function automatic int unsigned vlmax_of(vtype_t vt);
    int unsigned base;
    base = VLEN / sew_bits(vt);
    case (vt.vlmul)
      LMUL_2:   return base * 2;
      LMUL_4:   return base * 4;
      LMUL_8:   return base * 8;
      LMUL_1_2: return base / 2;
      LMUL_1_4: return base / 4;
      LMUL_1_8: return base / 8;
      default:  return base;
    endcase
  endfunction

  function automatic int unsigned lmul_int(vtype_t vt);
    case (vt.vlmul)
      LMUL_2:  return 2;
      LMUL_4:  return 4;
      LMUL_8:  return 8;
      default: return 1;
    endcase
  endfunction

  // Returns 0 for a funct6 that the class lacks
  function automatic bit op_lookup(logic [5:0] f6, logic [2:0] f3, output vop_e op);
    op = VADD;
    case (f6)
      6'b000000: op = VADD;
      6'b000010: op = VSUB;
      6'b000011: op = VRSUB;
      6'b000100: op = VMINU;
      6'b000101: op = VMIN;
      6'b000110: op = VMAXU;
      6'b000111: op = VMAX;
      6'b001001: op = VAND;
      6'b001010: op = VOR;
      6'b001011: op = VXOR;
      6'b010111: op = VMERGE;
      6'b100101: op = VSLL;
      6'b101000: op = VSRL;
      6'b101001: op = VSRA;
      default:   return 0;
    endcase
    // No VV form of reverse subtract and no VI form of subtract, min or max
    if (op == VRSUB) begin
      return f3 != OPIVV;
    end
    if (op inside {VSUB, VMINU, VMIN, VMAXU, VMAX}) begin
      return f3 != OPIVI;
    end
    return 1;
  endfunction

  // Expected answer and request before the reference state moves on
  task automatic model_step(input entry_t e, output acc_resp_t er, output ara_req_t eq,
                            output bit issue, output bit skip_result);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [4:0]  rs1f;
    logic [4:0]  rdf;
    logic [11:0] addr;
    logic [63:0] src;
    vtype_t      vt;
    vop_e        op;
    bit          ok;
    int unsigned n;
    opc = e.insn[6:0];
    f3 = e.insn[14:12];
    rs1f = e.insn[19:15];
    rdf = e.insn[11:7];
    er = '0;
    eq = '0;
    issue = 0;
    skip_result = 0;
    m_wait = 0;
    if (opc == OP_VEC && f3 == OPCFG) begin
      vt = '0;
      {vt.vma, vt.vta} = e.insn[31] ? e.rs2[7:6] : e.insn[27:26];
      vt.vsew = vew_e'(e.insn[31] ? e.rs2[4:2] : e.insn[24:22]);
      vt.vlmul = vlmul_e'(e.insn[31] ? {e.rs2[5], e.rs2[1:0]}
                                      : {e.insn[25], e.insn[21:20]});
      if (!vtype_legal(vt)) begin
        vt = '{vill: 1'b1, vma: 1'b0, vta: 1'b0, vsew: EW8, vlmul: LMUL_1};
        m_vl = 0;
      end else if (rs1f == 0 && rdf != 0) begin
        m_vl = vlmax_of(vt);
      end else if (rs1f != 0) begin
        m_vl = (e.rs1 < vlmax_of(vt)) ? e.rs1 : vlmax_of(vt);
      end
      m_wait = (vt != m_vtype);
      m_vtype = vt;
      er.result = m_vl;
    end else if (opc == OP_VEC && f3 inside {OPIVV, OPIVX, OPIVI}) begin
      ok = op_lookup(e.insn[31:26], f3, op);
      n = lmul_int(m_vtype);
      if (rdf % n != 0 || e.insn[24:20] % n != 0 || (f3 == OPIVV && rs1f % n != 0)) begin
        ok = 0;
      end
      ok = ok && !m_vtype.vill;
      er.error = !ok;
      issue = ok;
      eq.op = op;
      eq.vs2 = e.insn[24:20];
      eq.use_vs2 = 1'b1;
      eq.vd = rdf;
      eq.vm = e.insn[25];
      eq.vs1 = (f3 == OPIVV) ? rs1f : 5'd0;
      eq.use_vs1 = (f3 == OPIVV);
      eq.use_scalar_op = (f3 != OPIVV);
      if (f3 == OPIVX) eq.scalar_op = e.rs1;
      if (f3 == OPIVI) eq.scalar_op = 64'(signed'(rs1f));
      eq.vl = m_vl;
      eq.vstart = m_vstart;
      eq.vtype = m_vtype;
    end else if (opc == OP_SYSTEM && f3 != 3'b000 && f3 != 3'b100) begin
      addr = e.insn[31:20];
      src = f3[2] ? 64'(rs1f) : e.rs1;
      if (addr == CSR_VSTART) begin
        er.result = m_vstart;
        case (f3[1:0])
          2'b01:   m_vstart = src[15:0];
          2'b10:   m_vstart = m_vstart | src[15:0];
          default: m_vstart = m_vstart & ~src[15:0];
        endcase
      end else if (rs1f != 0 || f3[1:0] == 2'b01) begin
        er.error = 1'b1;
        skip_result = 1;
      end else if (addr == CSR_VL) begin
        er.result = m_vl;
      end else if (addr == CSR_VTYPE) begin
        er.result = {m_vtype.vill, 55'd0, m_vtype.vma, m_vtype.vta, m_vtype.vlmul[2],
                     m_vtype.vsew, m_vtype.vlmul[1:0]};
      end else if (addr == CSR_VLENB) begin
        er.result = VLEN / 8;
      end else begin
        er.error = 1'b1;
        skip_result = 1;
      end
    end else begin
      er.error = 1'b1;
    end
  endtask

  task automatic check_resp(string name, acc_resp_t exp, acc_resp_t act, bit skip_result);
    if (exp.trans_id !== act.trans_id || exp.error !== act.error ||
        (!skip_result && exp.result !== act.result)) begin
      $display("error %s: expected response %h, actual %h", name, exp, act);
      resp_errs++;
    end
  endtask

  task automatic check_req(string name, ara_req_t exp, ara_req_t act);
    if (exp !== act) begin
      $display("error %s: expected request %h, actual %h", name, exp, act);
      req_errs++;
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("error %s: expected %b, actual %b", name, exp, act);
      bit_errs++;
    end
  endtask

  task automatic apply_entry(int i);
    entry_t    e;
    acc_resp_t er;
    ara_req_t  eq;
    bit        issue;
    bit        skip;
    bit        blocked;
    bit        is_arith;
    bit        done;
    int        bp;
    int        hold;
    int        n;
    int        exp_n;
    e = tbl[i];
    blocked = m_wait && e.idle_low;
    is_arith = (e.insn[6:0] == OP_VEC) && (e.insn[14:12] inside {OPIVV, OPIVX, OPIVI});
    // Backend stalls arithmetic, the core's response port stalls the rest
    bp = e.idle_low ? 0 : $urandom % 4;
    exp_n = blocked ? 3 : bp;
    model_step(e, er, eq, issue, skip);
    er.trans_id = 3'(i);
    @(posedge clk_i);
    #1;
    acc_req_i = '{trans_id: 3'(i), insn: e.insn, rs1: e.rs1, rs2: e.rs2};
    acc_req_valid_i = 1'b1;
    n = 0;
    done = 0;
    while (!done) begin
      ara_idle_i = !(e.idle_low && n < 3);
      ara_req_ready_i = !is_arith || n >= bp;
      acc_resp_ready_i = is_arith || n >= bp;
      @(negedge clk_i);
      if (acc_resp_valid_o) begin
        done = 1;
        check_bit({e.name, " acc_req_ready_o"}, 1'b1, acc_req_ready_o);
        check_resp(e.name, er, acc_resp_o, skip);
        if (n != exp_n) begin
          $display("%s was accepted after %0d cycles instead of %0d", e.name, n, exp_n);
          bit_errs++;
        end
      end else begin
        check_bit({e.name, " acc_req_ready_o"}, 1'b0, acc_req_ready_o);
      end
      @(posedge clk_i);
      #1;
      n++;
    end
    acc_req_valid_i = 1'b0;
    acc_resp_ready_i = 1'b1;
    // Next entry may need the backend busy from its first cycle
    ara_idle_i = (i + 1 < tbl.size()) ? !tbl[i + 1].idle_low : 1'b1;
    if (issue) begin
      hold = $urandom % 4;
      for (int k = 0; k <= hold; k++) begin
        ara_req_ready_i = (k == hold);
        @(negedge clk_i);
        check_bit({e.name, " ara_req_valid_o"}, 1'b1, ara_req_valid_o);
        check_req(e.name, eq, ara_req_o);
        @(posedge clk_i);
        #1;
      end
    end else begin
      ara_req_ready_i = 1'b1;
      @(negedge clk_i);
      check_bit({e.name, " ara_req_valid_o"}, 1'b0, ara_req_valid_o);
    end
  endtask

  task automatic build_table();
    add("cfgi_e32m1", enc_cfgi(1, 10, 8'h08), $urandom % 40);
    add("rd_vl", enc_csr(CSR_VL, 0, CSR_FUNCT3_CSRRS));
    add("rd_vtype", enc_csr(CSR_VTYPE, 0, CSR_FUNCT3_CSRRS));
    add("cfgi_keep_vl_mf2", enc_cfgi(0, 0, 8'h23));
    add("rd_vl_kept", enc_csr(CSR_VL, 0, CSR_FUNCT3_CSRRS));
    add("cfgi_vlmax_m2", enc_cfgi(3, 0, 8'h05));
    add("rd_vl_vlmax", enc_csr(CSR_VL, 0, CSR_FUNCT3_CSRRS));
    add("cfg_e64m8", enc_cfg(4, 11, 12), $urandom % 96, 64'h4F);
    add("rd_vtype_m8", enc_csr(CSR_VTYPE, 0, CSR_FUNCT3_CSRRS));
    add("vadd_vv_m8", enc_op(6'b000000, 1, 16, 24, OPIVV, 8));
    add("vsub_vx_misaligned", enc_op(6'b000010, 1, 8, 5, OPIVX, 4), 64'h55);
    add("vsll_vi_m8", enc_op(6'b100101, 0, 8, 5'b11101, OPIVI, 0));
    add("vadd_vv_bad_vs1", enc_op(6'b000000, 1, 8, 4, OPIVV, 16));
    add("cfgi_e128", enc_cfgi(1, 10, 8'h10), 5);
    add("rd_vl_vill", enc_csr(CSR_VL, 0, CSR_FUNCT3_CSRRS));
    add("vadd_vill", enc_op(6'b000000, 1, 0, 0, OPIVV, 0));
    add("cfgi_rsvd_lmul", enc_cfgi(1, 10, 8'h20), 5);
    add("cfgi_small_lmul", enc_cfgi(1, 10, 8'h2D), 5);
    add("vxor_vill", enc_op(6'b001011, 1, 0, 3, OPIVX, 0), 64'h1);
    add("cfgi_e32m4", enc_cfgi(1, 10, 8'h0A), $urandom % 80);
    add("vmax_vx_m4", enc_op(6'b000111, 1, 4, 6, OPIVX, 12), 64'hffff_ffff_ffff_fff0);
    add("vrsub_vi_m4", enc_op(6'b000011, 1, 8, 5'b00111, OPIVI, 4));
    add("vand_vv_misaligned", enc_op(6'b001001, 1, 4, 2, OPIVV, 8));
    add("bad_funct6", enc_op(6'b000001, 1, 4, 8, OPIVV, 8));
    add("vmin_vi_bad", enc_op(6'b000101, 1, 4, 1, OPIVI, 8));
    add("vrsub_vv_bad", enc_op(6'b000011, 1, 4, 8, OPIVV, 8));
    add("opmvv", enc_op(6'b000000, 1, 4, 8, OPMVV, 8));
    add("unknown_opcode", 32'h0020_81b3);
    add("csrrw_vstart", enc_csr(CSR_VSTART, 5, CSR_FUNCT3_CSRRW), 7);
    add("csrrsi_vstart", enc_csr(CSR_VSTART, 5'h10, CSR_FUNCT3_CSRRSI));
    add("csrrc_vstart", enc_csr(CSR_VSTART, 5, CSR_FUNCT3_CSRRC), 3);
    add("csrrwi_vstart", enc_csr(CSR_VSTART, 5'h6, CSR_FUNCT3_CSRRWI));
    add("csrrci_vstart", enc_csr(CSR_VSTART, 5'h2, CSR_FUNCT3_CSRRCI));
    add("vor_vx_vstart", enc_op(6'b001010, 1, 8, 5, OPIVX, 4), 64'hdead_beef);
    add("rd_vlenb", enc_csr(CSR_VLENB, 0, CSR_FUNCT3_CSRRS));
    add("csrrw_vl_ro", enc_csr(CSR_VL, 3, CSR_FUNCT3_CSRRW), 9);
    add("csrrsi_vtype_ro", enc_csr(CSR_VTYPE, 1, CSR_FUNCT3_CSRRSI));
    add("cfgi_e16m1_change", enc_cfgi(1, 10, 8'h04), $urandom % 40);
    add("rd_vtype_blocked", enc_csr(CSR_VTYPE, 0, CSR_FUNCT3_CSRRS), 0, 0, 1);
    add("cfgi_e16m1_same", enc_cfgi(1, 10, 8'h04), $urandom % 40);
    add("rd_vl_not_blocked", enc_csr(CSR_VL, 0, CSR_FUNCT3_CSRRS), 0, 0, 1);
    add("vmerge_vi", enc_op(6'b010111, 0, 8, 5'b10000, OPIVI, 2));
  endtask

  // Watchdog sized from the table length
  initial begin
    wait (table_built);
    #(tbl.size() * 40 * CLK_PERIOD);
    $display("Timeout: the DUT stopped answering before the table was done");
    $display("Verification failed");
    $finish;
  end

  initial begin
    int unsigned total;
    void'($urandom(32'hd8c7f12e));
    rst_ni = 1'b0;
    acc_req_i = '0;
    acc_req_valid_i = 1'b0;
    acc_resp_ready_i = 1'b1;
    ara_req_ready_i = 1'b1;
    ara_idle_i = 1'b1;
    m_vtype = '{vill: 1'b1, vma: 1'b0, vta: 1'b0, vsew: EW8, vlmul: LMUL_1};
    m_vl = 0;
    m_vstart = 0;
    m_wait = 0;
    build_table();
    table_built = 1'b1;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int i = 0; i < tbl.size(); i++) begin
      apply_entry(i);
    end
    repeat (2) @(posedge clk_i);
    total = resp_errs + req_errs + bit_errs + u_dut.u_props.assert_fails;
    $display("Done: %0d response, %0d request, %0d strobe, %0d assertion errors",
             resp_errs, req_errs, bit_errs, u_dut.u_props.assert_fails);
    if (total == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
design/rvv_isa_pkg.sv
design/vdisp_pkg.sv
design/vcfg_csr_unit.sv
design/varith_decoder.sv
design/dispatch_ctrl.sv
design/vector_dispatcher.sv
sim/vector_dispatcher_properties.sv
sim/vector_dispatcher_tb.sv
